// File: source/readout_pkg.sv
package readout_pkg;

    //////////////////////////////////////////////////////////////////////
    // Board geometry and widths
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_CHANNELS   = 8;   // Receiver channels on the board
    localparam int ABUS_WIDTH     = 16;  // Local bus address
    localparam int BUS_DATA_WIDTH = 8;   // Byte-wide local bus
    localparam int DATA_WIDTH     = 32;  // Output word
    localparam int PAYLOAD_WIDTH  = 24;  // Decoded receiver payload
    localparam int IDENT_WIDTH    = 8;   // Channel tag in the upper byte

    localparam int CH_FIFO_DEPTH  = 8;   // Per channel buffer
    localparam int OUT_FIFO_DEPTH = 64;  // Shared output FIFO

    // Occupancy count and near-full threshold share this width
    localparam int LEVEL_WIDTH       = $clog2(OUT_FIFO_DEPTH + 1);
    localparam int NEAR_FULL_DEFAULT = 48;

    //////////////////////////////////////////////////////////////////////
    // Local bus address map
    //////////////////////////////////////////////////////////////////////

    localparam logic [ABUS_WIDTH-1:0] FIFO_ADDR     = 16'h8100; // Near-full threshold
    localparam logic [ABUS_WIDTH-1:0] STATUS_ADDR   = 16'h8101; // Flags and busy, read only
    localparam logic [ABUS_WIDTH-1:0] OVERFLOW_ADDR = 16'h8102; // Sticky, any write clears
    localparam logic [ABUS_WIDTH-1:0] DISABLE_ADDR  = 16'h8A00; // Channel disable mask

    typedef logic [PAYLOAD_WIDTH-1:0] payload_t;

    // Tagged output word
    typedef struct packed {
        logic [IDENT_WIDTH-1:0] ident;   // Channel index plus one
        payload_t               payload;
    } data_word_t;

    // One local bus cycle
    typedef struct packed {
        logic [ABUS_WIDTH-1:0]     add;
        logic [BUS_DATA_WIDTH-1:0] data;
        logic                      wr;   // One-cycle strobe
        logic                      rd;   // One-cycle strobe
    } bus_req_t;

    // LED flags of the output FIFO
    typedef struct packed {
        logic not_empty;
        logic full;
        logic near_full;
        logic read_error;
    } fifo_flags_t;

endpackage

// File: source/sync_fifo.sv
`timescale 1ns/100ps

// Show-ahead FIFO, head word always visible at rdata
module sync_fifo #(
    parameter type payload = logic,
    parameter int  depth   = 8
) (
    input  logic                       bus_clk,
    input  logic                       arst_n,
    input  logic                       wr,
    input  payload                     wdata,
    input  logic                       rd,
    output payload                     rdata,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(depth+1)-1:0] count
);

    localparam int PTR_WIDTH = (depth > 1) ? $clog2(depth) : 1;

    payload               mem [depth];  // Storage array
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic                 push;
    logic                 pop;

    // Circular pointer step, also for depths that are not a power of two
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push  = wr & ~full;   // Write into full is lost
    assign pop   = rd & ~empty;  // Read of empty is lost
    assign empty = (count == '0);
    assign full  = (count == $bits(count)'(depth));
    assign rdata = mem[rd_ptr];  // First word fall-through

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge bus_clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leaves count as is
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/rx_channel.sv
`timescale 1ns/100ps

// One receiver channel
// Decoded words arrive on a plain valid strobe, get tagged and buffered
module rx_channel #(
    parameter int ident = 1  // Channel index plus one
) (
    input  logic                    bus_clk,
    input  logic                    arst_n,
    input  logic                    rx_valid,      // One-cycle word strobe
    input  readout_pkg::payload_t   rx_payload,
    input  logic                    chan_disable,  // From the disable mask
    input  logic                    chan_read,     // Grant from the arbiter
    output readout_pkg::data_word_t chan_word,     // Head of the buffer
    output logic                    chan_empty,
    output logic                    overflow       // One-cycle drop pulse
);

    readout_pkg::data_word_t tagged_word;
    logic                    accept;
    logic                    buf_full;

    // Disabled channel ignores its strobes entirely
    assign accept = rx_valid & ~chan_disable;

    // Tag goes into the upper byte
    always_comb begin
        tagged_word.ident   = readout_pkg::IDENT_WIDTH'(ident);
        tagged_word.payload = rx_payload;
    end

    //////////////////////////////////////////////////////////////////////
    // Channel buffer
    //////////////////////////////////////////////////////////////////////

    sync_fifo #(
        .payload(readout_pkg::data_word_t),
        .depth  (readout_pkg::CH_FIFO_DEPTH)
    ) chan_buf (
        .bus_clk(bus_clk),
        .arst_n (arst_n),
        .wr     (accept),       // Buffer itself drops on full
        .wdata  (tagged_word),
        .rd     (chan_read),
        .rdata  (chan_word),    // Visible the cycle after the strobe
        .empty  (chan_empty),
        .full   (buf_full),
        .count  ()              // Occupancy not needed here
    );

    // Strobe meeting a full buffer means a lost word
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            overflow <= 1'b0;
        end else begin
            overflow <= accept & buf_full;
        end
    end

endmodule

// File: source/readout_regs.sv
`timescale 1ns/100ps

// Byte-wide local bus registers
module readout_regs (
    input  logic                                       bus_clk,
    input  logic                                       arst_n,
    input  readout_pkg::bus_req_t                      bus_req,
    output logic [readout_pkg::BUS_DATA_WIDTH-1:0]     bus_rdata,
    output logic [readout_pkg::NUM_CHANNELS-1:0]       chan_disable,
    output logic [readout_pkg::LEVEL_WIDTH-1:0]        near_full_level,
    input  logic [readout_pkg::NUM_CHANNELS-1:0]       overflow,      // Pulses from channels
    input  readout_pkg::fifo_flags_t                   flags,
    input  logic                                       busy
);

    logic [readout_pkg::NUM_CHANNELS-1:0]   overflow_sticky;
    logic [readout_pkg::BUS_DATA_WIDTH-1:0] rdata_next;
    logic                                   sel_fifo;
    logic                                   sel_status;
    logic                                   sel_overflow;
    logic                                   sel_disable;

    // Address decode, full match only
    assign sel_fifo     = (bus_req.add == readout_pkg::FIFO_ADDR);
    assign sel_status   = (bus_req.add == readout_pkg::STATUS_ADDR);
    assign sel_overflow = (bus_req.add == readout_pkg::OVERFLOW_ADDR);
    assign sel_disable  = (bus_req.add == readout_pkg::DISABLE_ADDR);

    //////////////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            chan_disable    <= '0;  // All channels on
            near_full_level <= readout_pkg::LEVEL_WIDTH'(readout_pkg::NEAR_FULL_DEFAULT);
        end else if (bus_req.wr) begin
            if (sel_disable) begin
                chan_disable <= readout_pkg::NUM_CHANNELS'(bus_req.data);
            end
            if (sel_fifo) begin
                near_full_level <= readout_pkg::LEVEL_WIDTH'(bus_req.data);
            end
        end
    end

    // Sticky overflow, a new pulse wins over a clear in the same cycle
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            overflow_sticky <= '0;
        end else if (bus_req.wr && sel_overflow) begin
            overflow_sticky <= overflow;
        end else begin
            overflow_sticky <= overflow_sticky | overflow;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rdata_next = '0;  // Unmapped reads
        if (sel_fifo) begin
            rdata_next = readout_pkg::BUS_DATA_WIDTH'(near_full_level);
        end else if (sel_status) begin
            rdata_next = {3'b000, busy, flags.read_error, flags.near_full,
                          flags.full, flags.not_empty};  // LED order in bits 0..3
        end else if (sel_overflow) begin
            rdata_next = readout_pkg::BUS_DATA_WIDTH'(overflow_sticky);
        end else if (sel_disable) begin
            rdata_next = readout_pkg::BUS_DATA_WIDTH'(chan_disable);
        end
    end

    // Read data one cycle after the strobe, held until the next read
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_rdata <= '0;
        end else if (bus_req.rd) begin
            bus_rdata <= rdata_next;
        end
    end

endmodule

// File: source/rr_arbiter.sv
`timescale 1ns/100ps

// Round-robin drain of the channel buffers
module rr_arbiter (
    input  logic                                 bus_clk,
    input  logic                                 arst_n,
    input  logic [readout_pkg::NUM_CHANNELS-1:0] chan_empty,
    input  readout_pkg::data_word_t              chan_word [readout_pkg::NUM_CHANNELS],
    input  logic                                 out_full,   // Output FIFO cannot take a word
    output logic [readout_pkg::NUM_CHANNELS-1:0] chan_read,  // Combinational grant
    output logic                                 out_wr,
    output readout_pkg::data_word_t              out_word
);

    localparam int SEL_WIDTH = $clog2(readout_pkg::NUM_CHANNELS);

    logic [SEL_WIDTH-1:0] prio_ptr;   // Channel with first priority
    logic [SEL_WIDTH-1:0] grant_idx;
    logic                 found;
    logic                 grant;

    //////////////////////////////////////////////////////////////////////
    // Priority search
    //////////////////////////////////////////////////////////////////////

    // Walk backwards from the far end so the nearest request wins
    always_comb begin
        int idx;
        found     = 1'b0;
        grant_idx = prio_ptr;
        for (int k = readout_pkg::NUM_CHANNELS - 1; k >= 0; k--) begin
            idx = (int'(prio_ptr) + k) % readout_pkg::NUM_CHANNELS;
            if (!chan_empty[idx]) begin
                found     = 1'b1;
                grant_idx = SEL_WIDTH'(idx);
            end
        end
    end

    assign grant = found & ~out_full;  // Stall under back-pressure

    always_comb begin
        chan_read = '0;
        if (grant) begin
            chan_read[grant_idx] = 1'b1;  // Pops the head this cycle
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Rotation and output write
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            prio_ptr <= '0;  // Channel 0 first after reset
            out_wr   <= 1'b0;
        end else begin
            out_wr <= grant;
            if (grant) begin
                // Channel after the granted one goes first next time
                prio_ptr <= (grant_idx == SEL_WIDTH'(readout_pkg::NUM_CHANNELS - 1)) ?
                            '0 : grant_idx + 1'b1;
            end
        end
    end

    // Word captured with the grant, written one cycle later
    always_ff @(posedge bus_clk) begin
        if (grant) begin
            out_word <= chan_word[grant_idx];
        end
    end

endmodule

// File: source/readout_top.sv
`timescale 1ns/100ps

// Readout data path, eight receiver channels into one output FIFO
module readout_top (
    input  logic                                   bus_clk,
    input  logic                                   arst_n,
    input  readout_pkg::bus_req_t                  bus_req,
    output logic [readout_pkg::BUS_DATA_WIDTH-1:0] bus_rdata,
    input  logic [readout_pkg::NUM_CHANNELS-1:0]   rx_valid,
    input  readout_pkg::payload_t                  rx_payload [readout_pkg::NUM_CHANNELS],
    input  logic                                   out_read,   // Pop strobe
    output readout_pkg::data_word_t                out_data,   // Head of the output FIFO
    output readout_pkg::fifo_flags_t               flags,      // LED flags
    output logic                                   busy        // Trigger veto
);

    logic [readout_pkg::NUM_CHANNELS-1:0] chan_disable;
    logic [readout_pkg::NUM_CHANNELS-1:0] overflow;
    logic [readout_pkg::NUM_CHANNELS-1:0] chan_empty;
    logic [readout_pkg::NUM_CHANNELS-1:0] chan_read;
    readout_pkg::data_word_t              chan_word [readout_pkg::NUM_CHANNELS];
    logic [readout_pkg::LEVEL_WIDTH-1:0]  near_full_level;
    logic [readout_pkg::LEVEL_WIDTH-1:0]  out_count;
    readout_pkg::data_word_t              out_word;
    logic                                 out_wr;
    logic                                 out_empty;
    logic                                 out_full;
    logic                                 arb_full;
    logic                                 read_error;

    //////////////////////////////////////////////////////////////////////
    // Registers and channels
    //////////////////////////////////////////////////////////////////////

    readout_regs u_regs (
        .bus_clk        (bus_clk),
        .arst_n         (arst_n),
        .bus_req        (bus_req),
        .bus_rdata      (bus_rdata),
        .chan_disable   (chan_disable),
        .near_full_level(near_full_level),
        .overflow       (overflow),
        .flags          (flags),
        .busy           (busy)
    );

    for (genvar g = 0; g < readout_pkg::NUM_CHANNELS; g++) begin : g_chan
        rx_channel #(
            .ident(g + 1)  // Ident 0 stays unused
        ) u_chan (
            .bus_clk     (bus_clk),
            .arst_n      (arst_n),
            .rx_valid    (rx_valid[g]),
            .rx_payload  (rx_payload[g]),
            .chan_disable(chan_disable[g]),
            .chan_read   (chan_read[g]),
            .chan_word   (chan_word[g]),
            .chan_empty  (chan_empty[g]),
            .overflow    (overflow[g])
        );
    end

    // Last free slot already claimed by the write in flight
    assign arb_full = out_full |
        (out_wr & (out_count == readout_pkg::LEVEL_WIDTH'(readout_pkg::OUT_FIFO_DEPTH - 1)));

    rr_arbiter u_arb (
        .bus_clk   (bus_clk),
        .arst_n    (arst_n),
        .chan_empty(chan_empty),
        .chan_word (chan_word),
        .out_full  (arb_full),
        .chan_read (chan_read),
        .out_wr    (out_wr),
        .out_word  (out_word)
    );

    //////////////////////////////////////////////////////////////////////
    // Output FIFO and flags
    //////////////////////////////////////////////////////////////////////

    sync_fifo #(
        .payload(readout_pkg::data_word_t),
        .depth  (readout_pkg::OUT_FIFO_DEPTH)
    ) out_fifo (
        .bus_clk(bus_clk),
        .arst_n (arst_n),
        .wr     (out_wr),
        .wdata  (out_word),
        .rd     (out_read),
        .rdata  (out_data),
        .empty  (out_empty),
        .full   (out_full),
        .count  (out_count)
    );

    // Read of an empty FIFO latches until reset
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            read_error <= 1'b0;
        end else if (out_read && out_empty) begin
            read_error <= 1'b1;
        end
    end

    always_comb begin
        flags.not_empty  = ~out_empty;
        flags.full       = out_full;
        flags.near_full  = (out_count >= near_full_level);  // Threshold from the bus
        flags.read_error = read_error;
    end

    assign busy = out_full;  // Vetoes the trigger source

endmodule

// File: testbench/readout_model.svh
`ifndef READOUT_MODEL_SVH
`define READOUT_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference model of the readout path
//////////////////////////////////////////////////////////////////////

// Expected words per channel, in arrival order
logic [readout_pkg::DATA_WIDTH-1:0]   exp_q [readout_pkg::NUM_CHANNELS][$];
logic [readout_pkg::NUM_CHANNELS-1:0] shadow_mask;   // Disable mask as last written
logic [7:0]                           shadow_level;  // Near-full threshold as last written

// Back to the state the DUT has after reset
task automatic clear_model();
    foreach (exp_q[c]) begin
        exp_q[c].delete();
    end
    shadow_mask  = '0;
    shadow_level = 8'(readout_pkg::NEAR_FULL_DEFAULT);
endtask

// Disabled channel never buffers the word
task automatic expect_word(input int ch, input readout_pkg::payload_t payload);
    if (!shadow_mask[ch]) begin
        exp_q[ch].push_back({8'(ch + 1), payload});  // Ident is index plus one
    end
endtask

task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        errors++;
    end
endtask

// Ident selects the queue, whole word must match its front
task automatic verify_popped_word(input readout_pkg::data_word_t word);
    int ch;
    ch = int'(word.ident) - 1;
    if (ch < 0 || ch >= readout_pkg::NUM_CHANNELS || shadow_mask[ch] ||
        exp_q[ch].size() == 0) begin
        $display("Popped word %h has a bad ident, a disabled channel or no pending word", word);
        errors++;
    end else begin
        compare_value("out_data", word, exp_q[ch].pop_front());
    end
endtask

function automatic bit all_queues_empty();
    foreach (exp_q[c]) begin
        if (exp_q[c].size() != 0) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

`endif

// File: testbench/tb_readout_top.sv
`timescale 1ns/100ps

module tb_readout_top;

    localparam int NCH            = readout_pkg::NUM_CHANNELS;
    localparam int TRAFFIC_CYCLES = 400;  // Per random traffic phase
    localparam int DRAIN_LIMIT    = 200;  // Bound on any drain
    // Summed phase lengths in cycles, watchdog allows four times this
    localparam int PHASE_CYCLES   = 40 + 3 * TRAFFIC_CYCLES + 6 * DRAIN_LIMIT +
                                    4 * readout_pkg::OUT_FIFO_DEPTH;

    logic                                   bus_clk;
    logic                                   arst_n;
    readout_pkg::bus_req_t                  bus_req;
    logic [readout_pkg::BUS_DATA_WIDTH-1:0] bus_rdata;
    logic [NCH-1:0]                         rx_valid;
    readout_pkg::payload_t                  rx_payload [NCH];
    logic                                   out_read;
    readout_pkg::data_word_t                out_data;
    readout_pkg::fifo_flags_t               flags;
    logic                                   busy;
    int                                     errors;
    int                                     checks;

    `include "readout_model.svh"

    readout_top UUT (.*);

    always #2 bus_clk = ~bus_clk;  // 4 ns period

    initial begin : watchdog
        #(PHASE_CYCLES * 4 * 4);
        $display("Watchdog expired after %0d cycles, the run did not finish", PHASE_CYCLES * 4);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Drive helpers
    //////////////////////////////////////////////////////////////////////

    // Drive point just after the rising edge, strobes back to idle
    task automatic step();
        @(posedge bus_clk);
        #0.5;
        bus_req  = '0;
        rx_valid = '0;
        out_read = 1'b0;
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (5) @(posedge bus_clk);
        #0.5;
        arst_n = 1'b1;
        clear_model();
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        step();
        bus_req.add  = addr;
        bus_req.data = data;
        bus_req.wr   = 1'b1;
        step();
        if (addr == readout_pkg::DISABLE_ADDR) shadow_mask = data;
        if (addr == readout_pkg::FIFO_ADDR) shadow_level = data;
    endtask

    // Read data lands one cycle after the strobe
    task automatic read_check(input logic [15:0] addr, input logic [7:0] exp, input string name);
        step();
        bus_req.add = addr;
        bus_req.rd  = 1'b1;
        step();
        compare_value(name, bus_rdata, exp);
    endtask

    // One cycle of random strobes, rate 0 means no strobes
    task automatic traffic_cycle(input int rate, input bit drain);
        step();
        if (drain && flags.not_empty) begin
            verify_popped_word(out_data);
            out_read = 1'b1;
        end
        for (int c = 0; c < NCH; c++) begin
            rx_payload[c] = readout_pkg::PAYLOAD_WIDTH'($urandom);
            rx_valid[c]   = (rate > 0) && ($urandom % rate == 0);
            if (rx_valid[c]) expect_word(c, rx_payload[c]);
        end
    endtask

    task automatic drain_all();
        int n;
        n = 0;
        while (!all_queues_empty() && n < DRAIN_LIMIT) begin
            traffic_cycle(0, 1'b1);
            n++;
        end
        step();  // Last pop lands
        if (!all_queues_empty()) begin
            $display("Drain left expected words behind after %0d cycles", DRAIN_LIMIT);
            errors++;
        end
        compare_value("flags.not_empty", flags.not_empty, 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test phases
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        int          ch;
        int          held;
        int          popped;
        logic [7:0]  mask;
        errors   = 0;
        checks   = 0;
        bus_clk  = 1'b0;
        arst_n   = 1'b0;
        bus_req  = '0;
        rx_valid = '0;
        out_read = 1'b0;
        foreach (rx_payload[c]) rx_payload[c] = '0;
        void'($urandom(32'hdb81));  // Only seeding of the run
        apply_reset();

        // Reset state
        compare_value("flags", flags, 4'h0);
        compare_value("busy", busy, 1'b0);
        read_check(readout_pkg::DISABLE_ADDR, 8'h00, "disable mask");
        read_check(readout_pkg::FIFO_ADDR, 8'(readout_pkg::NEAR_FULL_DEFAULT), "near_full_level");

        // Random traffic, reads keep up
        repeat (TRAFFIC_CYCLES) traffic_cycle(16, 1'b1);
        drain_all();
        read_check(readout_pkg::OVERFLOW_ADDR, 8'h00, "overflow");

        // Channel 0 always off, channel 7 always on
        mask = (8'($urandom) | 8'h01) & 8'h7F;
        bus_write(readout_pkg::DISABLE_ADDR, mask);
        read_check(readout_pkg::DISABLE_ADDR, mask, "disable mask");
        repeat (TRAFFIC_CYCLES) traffic_cycle(16, 1'b1);
        drain_all();
        bus_write(readout_pkg::DISABLE_ADDR, 8'h00);

        // Round robin from a fresh priority pointer
        apply_reset();
        for (int r = 0; r < 4; r++) begin
            step();
            rx_valid = '1;
            for (int c = 0; c < NCH; c++) begin
                rx_payload[c] = readout_pkg::PAYLOAD_WIDTH'($urandom);
                expect_word(c, rx_payload[c]);
            end
        end
        popped = 0;
        for (int n = 0; n < DRAIN_LIMIT && popped < 4 * NCH; n++) begin
            step();
            if (flags.not_empty) begin
                compare_value("out_data.ident", out_data.ident, (popped % NCH) + 1);
                verify_popped_word(out_data);
                out_read = 1'b1;
                popped++;
            end
        end
        drain_all();

        // Back-pressure, one word at a time until full
        bus_write(readout_pkg::FIFO_ADDR, 8'd20);
        held = 0;
        while (!flags.full && held < readout_pkg::OUT_FIFO_DEPTH + 8) begin
            step();
            rx_valid[held % NCH]   = 1'b1;
            rx_payload[held % NCH] = readout_pkg::PAYLOAD_WIDTH'($urandom);
            expect_word(held % NCH, rx_payload[held % NCH]);
            held++;
            repeat (3) step();  // Channel, grant, FIFO write
            compare_value("flags.near_full", flags.near_full, held >= shadow_level);
            compare_value("flags.full", flags.full, held == readout_pkg::OUT_FIFO_DEPTH);
            compare_value("busy", busy, held == readout_pkg::OUT_FIFO_DEPTH);
        end
        compare_value("words until full", held, readout_pkg::OUT_FIFO_DEPTH);
        ch = $urandom % NCH;
        for (int i = 0; i < readout_pkg::CH_FIFO_DEPTH + 3; i++) begin
            step();
            rx_valid[ch]   = 1'b1;
            rx_payload[ch] = readout_pkg::PAYLOAD_WIDTH'($urandom);
            if (i < readout_pkg::CH_FIFO_DEPTH) expect_word(ch, rx_payload[ch]);  // Rest dropped
        end
        read_check(readout_pkg::OVERFLOW_ADDR, 8'(1 << ch), "overflow");
        drain_all();
        bus_write(readout_pkg::OVERFLOW_ADDR, 8'h5A);
        read_check(readout_pkg::OVERFLOW_ADDR, 8'h00, "overflow");

        // Read error, sticky through traffic
        compare_value("flags.read_error", flags.read_error, 1'b0);
        step();
        out_read = 1'b1;  // FIFO is empty here
        step();
        compare_value("flags.read_error", flags.read_error, 1'b1);
        read_check(readout_pkg::STATUS_ADDR, 8'h08, "status");
        repeat (TRAFFIC_CYCLES / 2) traffic_cycle(16, 1'b1);
        drain_all();
        compare_value("flags.read_error", flags.read_error, 1'b1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: readout_top.f
+incdir+testbench
source/readout_pkg.sv
source/sync_fifo.sv
source/rx_channel.sv
source/readout_regs.sv
source/rr_arbiter.sv
source/readout_top.sv
testbench/tb_readout_top.sv
